// File: all.f
+incdir+hdl
+incdir+verification
hdl/cmd_pkg.sv
hdl/cmd_regs.sv
hdl/cmd_pattern_mem.sv
hdl/cmd_sequencer.sv
hdl/cmd_serializer.sv
hdl/cmd_encoder_top.sv
verification/tb_cmd_encoder.sv

// File: hdl/cmd_encoder_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Command encoder top. Bus and serial side share CMD_CLK.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "cmd_settings.svh"

module cmd_encoder_top import cmd_pkg::*; (
    input  wire                    CMD_CLK,
    input  wire                    RST_SYNC,
    input  wire [`CMD_BUS_AW-1:0]  bus_add,
    input  wire [`CMD_BUS_DW-1:0]  bus_data_in,
    input  wire                    bus_wr,
    input  wire                    bus_rd,
    output logic [`CMD_BUS_DW-1:0] bus_data_out,
    output logic                   serial_out,
    output logic                   cmd_en,
    output logic                   cmd_output_en,
    output logic                   cmd_writing,
    output logic                   cmd_loop_start
);

    logic                   start_pulse, soft_rst, output_en;
    logic                   core_rst;
    logic [15:0]            conf_size, conf_repeat;
    logic [`CMD_BUS_DW-1:0] mem_rd_data, rd_data, load_byte;
    logic                   mem_sel_q;
    logic [`CMD_MEM_AW-1:0] rd_addr;
    logic                   syncing, cmd_done, byte_tick;
    cmd_state_t             state;

    assign core_rst = RST_SYNC | soft_rst;  // Soft reset restarts the line

    cmd_regs cmd_regs_inst (
        .CMD_CLK, .RST_SYNC, .bus_add, .bus_data_in, .bus_wr, .bus_rd,
        .mem_rd_data, .mem_sel_q, .syncing, .cmd_done,
        .bus_data_out, .start_pulse, .soft_rst, .conf_size, .conf_repeat, .output_en
    );

    cmd_pattern_mem cmd_pattern_mem_inst (
        .CMD_CLK, .bus_add, .bus_data_in, .bus_wr, .bus_rd,
        .bus_rd_data(mem_rd_data), .mem_sel_q, .rd_addr, .rd_data
    );

    cmd_sequencer cmd_sequencer_inst (
        .CMD_CLK, .RST_SYNC(core_rst), .start_pulse, .conf_size, .conf_repeat,
        .byte_tick, .rd_data, .rd_addr, .load_byte, .state,
        .cmd_writing, .cmd_loop_start, .cmd_done, .syncing
    );

    cmd_serializer cmd_serializer_inst (
        .CMD_CLK, .RST_SYNC(core_rst), .state, .load_byte, .output_en,
        .byte_tick, .serial_out, .cmd_en, .cmd_output_en
    );

endmodule

`default_nettype wire

// File: hdl/cmd_pattern_mem.sv
// ~~~~~~~~~~~~~~~~~~~~
// Command byte store. Both ports read with one cycle latency.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "cmd_settings.svh"

module cmd_pattern_mem (
    input  wire                    CMD_CLK,
    input  wire [`CMD_BUS_AW-1:0]  bus_add,
    input  wire [`CMD_BUS_DW-1:0]  bus_data_in,
    input  wire                    bus_wr,
    input  wire                    bus_rd,
    output logic [`CMD_BUS_DW-1:0] bus_rd_data,
    output logic                   mem_sel_q,
    input  wire [`CMD_MEM_AW-1:0]  rd_addr,
    output logic [`CMD_BUS_DW-1:0] rd_data
);

    logic [`CMD_BUS_DW-1:0] mem [0:(1 << `CMD_MEM_AW)-1];
    logic [`CMD_BUS_AW-1:0] mem_off;
    logic                   hit;

    assign mem_off = bus_add - `CMD_REG_COUNT;
    assign hit = (bus_add >= `CMD_REG_COUNT) && ((mem_off >> `CMD_MEM_AW) == '0);

    always_ff @(posedge CMD_CLK) begin
        if (bus_wr && hit)
            mem[mem_off[`CMD_MEM_AW-1:0]] <= bus_data_in;
        if (bus_rd && hit)
            bus_rd_data <= mem[mem_off[`CMD_MEM_AW-1:0]];
        mem_sel_q <= bus_rd && hit;         // Tells the regs whose byte is out
        rd_data   <= mem[rd_addr];          // Sequencer port
    end

endmodule

`default_nettype wire

// File: hdl/cmd_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Types shared by the encoder modules.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cmd_pkg;

    // Sequencer phases
    typedef enum logic [1:0] {
        INIT = 2'd0,    // Toggle pattern for PLL lock
        SYNC = 2'd1,
        DATA = 2'd2
    } cmd_state_t;

    // Flags register fields
    typedef struct packed {
        logic [2:0] unused_hi;
        logic       output_en;  // Writable, 1 after reset
        logic [1:0] unused_lo;
        logic       syncing;    // Read only
        logic       conf_done;  // Read only
    } cmd_flags_t;

    // Bus byte or decoded fields
    typedef union packed {
        logic [7:0] raw;
        cmd_flags_t f;
    } cmd_flags_u;

endpackage

`default_nettype wire

// File: hdl/cmd_regs.sv
// ~~~~~~~~~~~~~~~~~~~~
// Register file and bus read path. Read data comes one cycle after
// bus_rd, and is 0 when no read was issued.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "cmd_settings.svh"

module cmd_regs import cmd_pkg::*; (
    input  wire                    CMD_CLK,
    input  wire                    RST_SYNC,
    input  wire [`CMD_BUS_AW-1:0]  bus_add,
    input  wire [`CMD_BUS_DW-1:0]  bus_data_in,
    input  wire                    bus_wr,
    input  wire                    bus_rd,
    input  wire [`CMD_BUS_DW-1:0]  mem_rd_data,
    input  wire                    mem_sel_q,
    input  wire                    syncing,
    input  wire                    cmd_done,
    output logic [`CMD_BUS_DW-1:0] bus_data_out,
    output logic                   start_pulse,
    output logic                   soft_rst,
    output logic [15:0]            conf_size,
    output logic [15:0]            conf_repeat,
    output logic                   output_en
);

    logic [7:0]             size_lo, size_hi;
    logic [7:0]             repeat_lo, repeat_hi;
    logic                   conf_done;
    cmd_flags_u             wr_flags;
    cmd_flags_u             rd_flags;
    logic [`CMD_BUS_DW-1:0] reg_value;
    logic [`CMD_BUS_DW-1:0] reg_rd_q;

    // Decoded in the write cycle so regs and core reset on the same edge
    assign soft_rst    = bus_wr && (bus_add == `CMD_ADDR_RESET);
    assign start_pulse = bus_wr && (bus_add == `CMD_ADDR_START);

    assign conf_size   = {size_hi, size_lo};
    assign conf_repeat = {repeat_hi, repeat_lo};

    always_comb begin
        wr_flags.raw = bus_data_in;
        rd_flags = '0;
        rd_flags.f.output_en = output_en;
        rd_flags.f.syncing   = syncing;
        rd_flags.f.conf_done = conf_done;
    end

    always_ff @(posedge CMD_CLK) begin
        if (RST_SYNC || soft_rst) begin
            output_en <= 1'b1;
            size_lo   <= '0;
            size_hi   <= '0;
            repeat_lo <= 8'd1;      // One pass by default
            repeat_hi <= '0;
        end else if (bus_wr) begin
            case (bus_add)
                `CMD_ADDR_FLAGS:     output_en <= wr_flags.f.output_en;
                `CMD_ADDR_SIZE_LO:   size_lo   <= bus_data_in;
                `CMD_ADDR_SIZE_HI:   size_hi   <= bus_data_in;
                `CMD_ADDR_REPEAT_LO: repeat_lo <= bus_data_in;
                `CMD_ADDR_REPEAT_HI: repeat_hi <= bus_data_in;
                default: ;
            endcase
        end
    end

    // Empty commands never finish, so they leave conf_done set
    always_ff @(posedge CMD_CLK) begin
        if (RST_SYNC || soft_rst)
            conf_done <= 1'b1;
        else if (start_pulse && conf_size != 16'd0)
            conf_done <= 1'b0;
        else if (cmd_done)
            conf_done <= 1'b1;
    end

    always_comb begin
        case (bus_add)
            `CMD_ADDR_RESET:     reg_value = `CMD_VERSION;
            `CMD_ADDR_FLAGS:     reg_value = rd_flags.raw;
            `CMD_ADDR_SIZE_LO:   reg_value = size_lo;
            `CMD_ADDR_SIZE_HI:   reg_value = size_hi;
            `CMD_ADDR_REPEAT_LO: reg_value = repeat_lo;
            `CMD_ADDR_REPEAT_HI: reg_value = repeat_hi;
            default:             reg_value = '0;  // Memory window included
        endcase
    end

    always_ff @(posedge CMD_CLK)
        reg_rd_q <= bus_rd ? reg_value : '0;

    assign bus_data_out = mem_sel_q ? mem_rd_data : reg_rd_q;

    // Register and memory windows never answer the same read
    a_one_read_source: assert property (@(posedge CMD_CLK) disable iff (RST_SYNC)
        mem_sel_q |-> (reg_rd_q == '0));

endmodule

`default_nettype wire

// File: hdl/cmd_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~
// Chooses the next byte for the serializer. Sizes above the
// memory depth end at the last memory byte; repeat 0 acts as 1.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "cmd_settings.svh"

module cmd_sequencer import cmd_pkg::*; (
    input  wire                    CMD_CLK,
    input  wire                    RST_SYNC,
    input  wire                    start_pulse,
    input  wire [15:0]             conf_size,
    input  wire [15:0]             conf_repeat,
    input  wire                    byte_tick,
    input  wire [`CMD_BUS_DW-1:0]  rd_data,
    output logic [`CMD_MEM_AW-1:0] rd_addr,
    output logic [`CMD_BUS_DW-1:0] load_byte,
    output cmd_state_t             state,
    output logic                   cmd_writing,
    output logic                   cmd_loop_start,
    output logic                   cmd_done,
    output logic                   syncing
);

    localparam logic [15:0] sync_word = `CMD_SYNC_WORD;

    logic [15:0] repeat_cnt;
    logic [15:0] addr_ext;
    logic        data_pending;
    logic        sync_hi;       // High sync byte goes out next
    logic        byte_is_data;  // Serializer holds a memory byte
    logic        loop_mark;
    logic        last_byte;
    logic        last_rep;

    assign addr_ext  = {{(16 - `CMD_MEM_AW){1'b0}}, rd_addr};
    assign last_byte = (addr_ext + 16'd1 >= conf_size) || (&rd_addr);
    assign last_rep  = (repeat_cnt + 16'd1 >= conf_repeat);
    assign syncing   = (state == SYNC);

    always_comb begin
        if (state == DATA)
            load_byte = rd_data;
        else
            load_byte = sync_hi ? sync_word[15:8] : sync_word[7:0];
    end

    always_ff @(posedge CMD_CLK) begin
        if (RST_SYNC) begin
            state          <= INIT;
            rd_addr        <= '0;
            repeat_cnt     <= '0;
            data_pending   <= 1'b0;
            sync_hi        <= 1'b1;
            byte_is_data   <= 1'b0;
            loop_mark      <= 1'b0;
            cmd_writing    <= 1'b0;
            cmd_loop_start <= 1'b0;
            cmd_done       <= 1'b0;
        end else begin
            cmd_done       <= 1'b0;
            cmd_writing    <= byte_is_data;  // Lines up with serial_out
            cmd_loop_start <= loop_mark;

            case (state)
                INIT: if (start_pulse) state <= SYNC;
                SYNC: if (byte_tick) begin
                    sync_hi <= ~sync_hi;
                    // Low byte leaving means the word is complete
                    if (!sync_hi && data_pending) begin
                        state      <= DATA;
                        rd_addr    <= '0;
                        repeat_cnt <= '0;
                    end
                end
                DATA: if (byte_tick) begin
                    if (last_byte) begin
                        rd_addr <= '0;
                        if (last_rep) begin
                            state        <= SYNC;
                            sync_hi      <= 1'b1;
                            data_pending <= 1'b0;
                            cmd_done     <= 1'b1;
                            repeat_cnt   <= '0;
                        end else begin
                            repeat_cnt <= repeat_cnt + 16'd1;
                        end
                    end else begin
                        rd_addr <= rd_addr + 1'b1;
                    end
                end
                default: state <= INIT;
            endcase

            if (byte_tick) begin
                byte_is_data <= (state == DATA);
                loop_mark    <= (state == DATA) && (rd_addr == '0) && (conf_repeat != 16'd1);
            end

            // A new start wins over the clear at the end of a command
            if (start_pulse && conf_size != 16'd0)
                data_pending <= 1'b1;
        end
    end

    a_addr_in_range: assert property (@(posedge CMD_CLK) disable iff (RST_SYNC)
        (state == DATA) |-> (addr_ext < conf_size));

endmodule

`default_nettype wire

// File: hdl/cmd_serializer.sv
// ~~~~~~~~~~~~~~~~~~~~
// MSB-first shifter. load_byte must be stable while byte_tick
// is high; serial_out trails the shift register by one cycle.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "cmd_settings.svh"

module cmd_serializer import cmd_pkg::*; (
    input  wire                    CMD_CLK,
    input  wire                    RST_SYNC,
    input  wire cmd_state_t        state,
    input  wire [`CMD_BUS_DW-1:0]  load_byte,
    input  wire                    output_en,
    output logic                   byte_tick,
    output logic                   serial_out,
    output logic                   cmd_en,
    output logic                   cmd_output_en
);

    logic [2:0]             bit_cnt;
    logic [`CMD_BUS_DW-1:0] shift_q;
    logic [2:0]             en_delay;   // Gives the PLL time before enable

    assign cmd_en = en_delay[2];

    always_ff @(posedge CMD_CLK) begin
        if (RST_SYNC) begin
            bit_cnt       <= '0;
            byte_tick     <= 1'b0;
            serial_out    <= 1'b0;
            en_delay      <= '0;
            cmd_output_en <= 1'b0;
        end else begin
            en_delay      <= {en_delay[1:0], state != INIT};
            cmd_output_en <= output_en;
            if (state == INIT) begin
                bit_cnt    <= '0;
                byte_tick  <= 1'b0;
                serial_out <= ~serial_out;      // 0101 lock pattern
            end else begin
                bit_cnt    <= bit_cnt + 3'd1;
                byte_tick  <= (bit_cnt == 3'd6);  // High with the last bit
                serial_out <= shift_q[`CMD_BUS_DW-1];
            end
        end
    end

    // Data path
    always_ff @(posedge CMD_CLK) begin
        if (state == INIT)
            shift_q <= '0;
        else if (byte_tick)
            shift_q <= load_byte;
        else
            shift_q <= {shift_q[`CMD_BUS_DW-2:0], 1'b0};
    end

    // The next byte has settled a cycle before it is taken
    a_byte_settled: assert property (@(posedge CMD_CLK) disable iff (RST_SYNC)
        byte_tick |-> $stable(load_byte));

endmodule

`default_nettype wire

// File: hdl/cmd_settings.svh
// ~~~~~~~~~~~~~~~~~~~~
// Bus, memory map and sync word of the command encoder.
// Address constants are sized to the 16-bit bus address.
// ~~~~~~~~~~~~~~~~~~~~
`ifndef CMD_SETTINGS_SVH
`define CMD_SETTINGS_SVH

`define CMD_BUS_AW         16
`define CMD_BUS_DW         8       // Also the serialized byte width
`define CMD_MEM_AW         8       // 256 command bytes

// Registers occupy the bottom of the bus map, the memory follows
`define CMD_REG_COUNT      16'd16

`define CMD_ADDR_RESET     16'd0   // Read gives version, write resets
`define CMD_ADDR_START     16'd1
`define CMD_ADDR_FLAGS     16'd2
`define CMD_ADDR_SIZE_LO   16'd3
`define CMD_ADDR_SIZE_HI   16'd4
`define CMD_ADDR_REPEAT_LO 16'd5
`define CMD_ADDR_REPEAT_HI 16'd6

`define CMD_VERSION        8'd2

// Sent high byte first between commands
`define CMD_SYNC_WORD      16'h817E

`endif

// File: run_sim.sh
#!/bin/sh
# Builds the command encoder testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cmd_encoder -f all.f -o tb_cmd_encoder_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_cmd_encoder_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi
exit 0

// File: verification/tb_cmd_tasks.svh
// ~~~~~~~~~~~~~~~~~~~~
// Bus tasks and directed tests, included in the testbench module.
// Every task starts and ends on a falling clock edge.
// ~~~~~~~~~~~~~~~~~~~~
`ifndef TB_CMD_TASKS_SVH
`define TB_CMD_TASKS_SVH

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        b = '0;
        for (int k = 0; k < 8; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
        return b;
    endfunction

    task automatic check_value(input logic [15:0] got, input logic [15:0] exp, input string what);
        assert (got === exp) else begin
            error_count++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        @(negedge CMD_CLK);
        bus_wr = 1'b0;
    endtask

    task automatic read_check(input logic [15:0] addr, input logic [7:0] exp, input string what);
        logic [7:0] got;
        bus_add = addr;
        bus_rd  = 1'b1;
        @(negedge CMD_CLK);
        got    = bus_data_out;           // Registered read lands one cycle later
        bus_rd = 1'b0;
        check_value(16'(got), 16'(exp), what);
    endtask

    // Polls cmd_en or cmd_writing until it reaches the level
    task automatic wait_for_flag(input bit on_en, input logic level, input int limit);
        int    n;
        string name;
        n = 0;
        if (on_en)
            name = "cmd_en";
        else
            name = "cmd_writing";
        while ((on_en ? cmd_en : cmd_writing) !== level && n < limit) begin
            @(negedge CMD_CLK);
            n++;
        end
        assert ((on_en ? cmd_en : cmd_writing) === level) else begin
            error_count++;
            $display("Waited %0d cycles but %s never became %b", limit, name, level);
        end
    endtask

    task automatic register_readback();
        read_check(`CMD_ADDR_RESET, 8'd2, "version");
        read_check(`CMD_ADDR_FLAGS, 8'h11, "flags after reset");   // output_en, conf_done
        bus_write(`CMD_ADDR_FLAGS, 8'hEE);                          // Clears output_en only
        read_check(`CMD_ADDR_FLAGS, 8'h01, "flags with output_en off");
        check_value(16'(cmd_output_en), 16'h0, "cmd_output_en");
        bus_write(`CMD_ADDR_FLAGS, 8'h10);
        bus_write(`CMD_ADDR_SIZE_LO, 8'h34);
        check_value(16'(cmd_output_en), 16'h1, "cmd_output_en restored");
        bus_write(`CMD_ADDR_SIZE_HI, 8'h12);
        bus_write(`CMD_ADDR_REPEAT_LO, 8'h07);
        bus_write(`CMD_ADDR_REPEAT_HI, 8'h01);
        read_check(`CMD_ADDR_SIZE_LO, 8'h34, "size low");
        read_check(`CMD_ADDR_SIZE_HI, 8'h12, "size high");
        read_check(`CMD_ADDR_REPEAT_LO, 8'h07, "repeat low");
        read_check(`CMD_ADDR_REPEAT_HI, 8'h01, "repeat high");
    endtask

    task automatic memory_readback();
        for (int i = 0; i < MEM_TEST_BYTES; i++) begin
            mem_model[i[5:0]] = random_byte();
            bus_write(16'(`CMD_REG_COUNT + i), mem_model[i[5:0]]);
        end
        for (int i = 0; i < MEM_TEST_BYTES; i++)
            read_check(16'(`CMD_REG_COUNT + i), mem_model[i[5:0]], "memory byte");
    endtask

    // Start with size 0 leaves INIT but sends only sync words
    task automatic sync_word_only();
        logic        found;
        logic [15:0] w;
        bus_write(`CMD_ADDR_SIZE_LO, 8'h00);
        bus_write(`CMD_ADDR_SIZE_HI, 8'h00);
        bus_write(`CMD_ADDR_REPEAT_HI, 8'h00);
        check_value(16'(cmd_en), 16'h0, "cmd_en before start");
        bus_write(`CMD_ADDR_START, 8'h00);
        wait_for_flag(1'b1, 1'b1, 8);
        repeat (48) @(negedge CMD_CLK);
        found = 1'b0;
        w     = '0;
        for (int k = 0; k < bit_q.size(); k++) begin
            w = {w[14:0], bit_q[k]};
            if (k >= 15 && w == 16'h817E)
                found = 1'b1;
        end
        assert (found) else begin
            error_count++;
            $display("[ERROR] %0t: sync word 817E missing from the serial stream", $time);
        end
        check_value(16'(cmd_en), 16'h1, "cmd_en after start");
        check_value(16'(data_q.size()), 16'h0, "data bits for size 0");
        read_check(`CMD_ADDR_FLAGS, 8'h13, "flags while syncing");
    endtask

    task automatic run_command(input int n, input int r);
        int         first;
        int         loops;
        logic       exp_q [$];
        logic [7:0] b;
        bus_write(`CMD_ADDR_SIZE_LO, 8'(n));
        bus_write(`CMD_ADDR_REPEAT_LO, 8'(r));
        first = data_q.size();
        loops = loop_count;
        bus_write(`CMD_ADDR_START, 8'h00);
        read_check(`CMD_ADDR_FLAGS, 8'h12, "flags after start");   // conf_done cleared
        wait_for_flag(1'b0, 1'b1, 48);
        wait_for_flag(1'b0, 1'b0, 8 * n * r + 8);
        read_check(`CMD_ADDR_FLAGS, 8'h13, "flags after command");
        for (int i = 0; i < r; i++)
            for (int j = 0; j < n; j++) begin
                b = mem_model[j[5:0]];
                repeat (8) begin
                    exp_q.push_back(b[7]);  // MSB first
                    b = b << 1;
                end
            end
        check_value(16'(data_q.size() - first), 16'(exp_q.size()), "data bit count");
        for (int k = 0; k < exp_q.size() && first + k < data_q.size(); k++)
            check_value(16'(data_q[first + k]), 16'(exp_q[k]), "data bit");
        check_value(pre_word, 16'h817E, "word ahead of the data");
        check_value(16'(loop_count > loops), 16'(r > 1), "loop start seen");
    endtask

    task automatic soft_reset_mid_command();
        logic prev;
        bus_write(`CMD_ADDR_SIZE_LO, 8'd20);
        bus_write(`CMD_ADDR_REPEAT_LO, 8'd3);
        bus_write(`CMD_ADDR_START, 8'h00);
        wait_for_flag(1'b0, 1'b1, 48);
        repeat (20) @(negedge CMD_CLK);
        bus_write(`CMD_ADDR_RESET, 8'h00);
        check_value(16'(cmd_writing), 16'h0, "cmd_writing after soft reset");
        check_value(16'(cmd_en), 16'h0, "cmd_en after soft reset");
        read_check(`CMD_ADDR_SIZE_LO, 8'h00, "size low after soft reset");
        read_check(`CMD_ADDR_SIZE_HI, 8'h00, "size high after soft reset");
        read_check(`CMD_ADDR_REPEAT_LO, 8'h01, "repeat low after soft reset");
        read_check(`CMD_ADDR_REPEAT_HI, 8'h00, "repeat high after soft reset");
        read_check(`CMD_ADDR_FLAGS, 8'h11, "flags after soft reset");
        prev = serial_out;
        repeat (8) begin
            @(negedge CMD_CLK);
            check_value(16'(serial_out), 16'(!prev), "toggle pattern bit");
            prev = serial_out;
        end
    endtask

`endif

// File: verification/tb_cmd_encoder.sv
// ~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the command encoder. Serial bits are
// sampled on the falling edge while cmd_en is high.
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "cmd_settings.svh"

module tb_cmd_encoder;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES   = 8;
    localparam int MEM_TEST_BYTES = 64;   // Memory model index is 6 bits wide
    // Data bits of all commands plus sync latency per command
    localparam int CMD_CYCLES     = 8 * (5 * 1 + 3 * 3 + 20) + 6 * 40;
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + 3 * MEM_TEST_BYTES + CMD_CYCLES + 200);

    logic                   CMD_CLK;
    logic                   RST_SYNC;
    logic [`CMD_BUS_AW-1:0] bus_add;
    logic [`CMD_BUS_DW-1:0] bus_data_in;
    logic                   bus_wr;
    logic                   bus_rd;
    logic [`CMD_BUS_DW-1:0] bus_data_out;
    logic                   serial_out;
    logic                   cmd_en;
    logic                   cmd_output_en;
    logic                   cmd_writing;
    logic                   cmd_loop_start;

    int          error_count = 0;
    int          cycle_count;
    logic [15:0] lfsr_state;
    logic [7:0]  mem_model [0:MEM_TEST_BYTES-1];

    // Serial monitor record
    logic        bit_q [$];
    logic        data_q [$];              // Bits seen while cmd_writing
    logic [15:0] bit_hist = '0;
    logic [15:0] pre_word = '0;           // 16 bits ahead of a data burst
    logic        writing_prev = 1'b0;
    int          loop_count = 0;

    cmd_encoder_top cmd_encoder_top_inst (
        .CMD_CLK, .RST_SYNC, .bus_add, .bus_data_in, .bus_wr, .bus_rd,
        .bus_data_out, .serial_out, .cmd_en, .cmd_output_en, .cmd_writing, .cmd_loop_start
    );

    `include "tb_cmd_tasks.svh"

    initial begin
        CMD_CLK = 1'b0;
        forever #50 CMD_CLK = ~CMD_CLK;
    end

    always @(negedge CMD_CLK) begin
        if (cmd_en) begin
            if (cmd_writing && !writing_prev)
                pre_word = bit_hist;
            bit_q.push_back(serial_out);
            bit_hist = {bit_hist[14:0], serial_out};
            if (cmd_writing)
                data_q.push_back(serial_out);
            if (cmd_loop_start)
                loop_count++;
        end
        writing_prev = cmd_writing;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge CMD_CLK);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors: %0d", error_count);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        lfsr_state  = 16'd32186;
        RST_SYNC    = 1'b1;
        bus_add     = '0;
        bus_data_in = '0;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        repeat (RESET_CYCLES) @(negedge CMD_CLK);
        RST_SYNC = 1'b0;
        @(negedge CMD_CLK);

        register_readback();
        memory_readback();
        sync_word_only();
        run_command(5, 1);
        run_command(3, 3);      // Looping command
        soft_reset_mid_command();

        $display("Errors: %0d", error_count);
        if (error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
